/* rv_exec.f */
design/rv_exec_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_operand_mux.sv
design/rv_alu.sv
design/rv_csr_file.sv
design/rv_writeback.sv
design/rv_exec_top.sv
tests/tb_clock_gen.sv
tests/tb_rv_exec.sv

/* Bender.yml */
package:
  name: rv_exec

sources:
  - files:
      - design/rv_exec_pkg.sv
      - design/rv_decoder.sv
      - design/rv_regfile.sv
      - design/rv_operand_mux.sv
      - design/rv_alu.sv
      - design/rv_csr_file.sv
      - design/rv_writeback.sv
      - design/rv_exec_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_rv_exec.sv

/* tests/tb_rv_exec.sv */
`timescale 1ns/100ps

module tb_rv_exec;
    import rv_exec_pkg::*;

    // instructions issued per test, each one takes two cycles
    localparam int instr_total = 2 + 28 + 16 + 4 + 22 + 6;
    localparam int cycle_limit = 2 * instr_total + 50;
    // {alt, funct3} per OP entry: add sub and or xor sll srl sra slt sltu
    localparam logic [39:0] reg_op_tab = {4'b0011, 4'b0010, 4'b1101, 4'b0101, 4'b0001,
                                          4'b0100, 4'b0110, 4'b0111, 4'b1000, 4'b0000};
    // addi xori slti slli srli srai
    localparam logic [23:0] imm_op_tab = {4'b1101, 4'b0101, 4'b0001, 4'b0010, 4'b0100, 4'b0000};
    localparam logic [47:0] csr_tab = {csr_mcause, csr_mepc, csr_mtvec, csr_mstatus};

    logic        clk;
    logic        reset;
    logic        instr_valid;
    instr_u      instr;
    logic [63:0] pc;
    wb_t         wb;

    logic [63:0] mregs [32];  // register model
    logic [63:0] m_mstatus;
    logic [63:0] m_mtvec;
    logic [63:0] m_mepc;
    logic [63:0] m_mcause;
    logic [63:0] cur_pc;
    logic [31:0] lfsr_state;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycle_count = 0;

    tb_clock_gen #(.period(4.0)) u_tb_clock_gen (.clk(clk), .reset(reset));

    rv_exec_top u_rv_exec_top (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb          (wb)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois, taps 32 22 2 1
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic logic [31:0] enc_r(input logic alt, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opcode);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    // expected result from the isa definition of each operation
    function automatic logic [63:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return {63'd0, $signed(a) < $signed(b)};
            3'd3: return {63'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[5:0];
                end
                return a >> b[5:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic writes_rd(input logic [31:0] w);
        case (w[6:0])
            op_reg, op_imm, op_lui, op_auipc, op_jal: return 1'b1;
            op_system: return w[14:12] == 3'b010;  // csrrs only
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [63:0] csr_ref(input logic [11:0] a);
        case (a)
            csr_mstatus: return m_mstatus;
            csr_mtvec:   return m_mtvec;
            csr_mepc:    return m_mepc;
            csr_mcause:  return m_mcause;
            default:     return 64'd0;
        endcase
    endfunction

    task automatic csr_update(input logic [11:0] a, input logic [63:0] mask);
        case (a)
            csr_mstatus: m_mstatus = m_mstatus | mask;
            csr_mtvec:   m_mtvec   = m_mtvec | mask;
            csr_mepc:    m_mepc    = m_mepc | mask;
            csr_mcause:  m_mcause  = m_mcause | mask;
            default: begin
            end
        endcase
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic exec_instr(input logic [31:0] word, input logic [63:0] exp_data,
                              input logic [63:0] exp_next, input logic chk_data);
        @(posedge clk);
        instr       <= word;
        pc          <= cur_pc;
        instr_valid <= 1'b1;
        @(posedge clk);
        instr_valid <= 1'b0;  // dut captured at this edge
        @(negedge clk);
        check_value("wb.valid", wb.valid, 1'b1);
        check_value("wb.rd", wb.rd, word[11:7]);
        if (chk_data) begin
            check_value("wb.data", wb.data, exp_data);
        end
        check_value("wb.next_pc", wb.next_pc, exp_next);
        if (writes_rd(word) && word[11:7] != 5'd0) begin
            mregs[word[11:7]] = exp_data;
        end
        cur_pc = exp_next;
    endtask

    // lui then addi, upper part rounded for a negative low part
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] upper;
        logic [63:0] lui_val;
        upper   = value[31:12] + value[11];
        lui_val = {{32{upper[19]}}, upper, 12'h000};
        exec_instr(enc_u(upper, rd, op_lui), lui_val, cur_pc + 4, 1'b1);
        exec_instr(enc_i(value[11:0], rd, 3'b000, rd, op_imm), lui_val + sext12(value[11:0]),
                   cur_pc + 4, 1'b1);
    endtask

    task automatic report_test(input string name, input int errs_start);
        tests++;
        if (errors == errs_start) begin
            $display("test %-10s ok", name);
        end else begin
            $display("test %-10s %0d errors", name, errors - errs_start);
        end
    endtask

    task automatic test_reset_x0();
        int errs_start;
        errs_start = errors;
        check_value("wb.valid", wb.valid, 1'b0);
        exec_instr(enc_i(12'd5, 5'd0, 3'b000, 5'd0, op_imm), 64'd5, cur_pc + 4, 1'b1);
        exec_instr(enc_r(1'b0, 5'd0, 5'd0, 3'b000, 5'd1), 64'd0, cur_pc + 4, 1'b1);
        @(posedge clk);
        @(negedge clk);
        check_value("wb.valid", wb.valid, 1'b0);  // idle cycle
        report_test("reset_x0", errs_start);
    endtask

    task automatic test_reg_ops();
        int          errs_start;
        logic [3:0]  op;
        errs_start = errors;
        for (int r = 0; r < 2; r++) begin
            load_reg(5'd1, rand_bits(32));
            load_reg(5'd2, rand_bits(32));
            for (int i = 0; i < 10; i++) begin
                op = reg_op_tab[i*4 +: 4];
                exec_instr(enc_r(op[3], 5'd2, 5'd1, op[2:0], 5'd3),
                           ref_alu(op[2:0], op[3], mregs[1], mregs[2]), cur_pc + 4, 1'b1);
            end
        end
        report_test("reg_ops", errs_start);
    endtask

    task automatic test_imm_forms();
        int          errs_start;
        logic [3:0]  op;
        logic [11:0] imm;
        logic [19:0] u;
        logic [63:0] rnd;
        errs_start = errors;
        load_reg(5'd4, rand_bits(32));
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 6; i++) begin
                op = imm_op_tab[i*4 +: 4];
                if (op[1:0] == 2'b01) begin
                    rnd = rand_bits(6);
                    imm = {1'b0, op[3], 4'b0, rnd[5:0]};  // shamt with funct7 bit
                end else begin
                    rnd = rand_bits(11);
                    imm = {r == 0, rnd[10:0]};  // negative in the first round
                end
                exec_instr(enc_i(imm, 5'd4, op[2:0], 5'd5, op_imm),
                           ref_alu(op[2:0], op[3], mregs[4], sext12(imm)), cur_pc + 4, 1'b1);
            end
        end
        u = rand_bits(20);
        exec_instr(enc_u(u, 5'd6, op_lui), {{32{u[19]}}, u, 12'h000}, cur_pc + 4, 1'b1);
        cur_pc = rand_bits(62) << 2;
        u = rand_bits(20);
        exec_instr(enc_u(u, 5'd7, op_auipc), cur_pc + {{32{u[19]}}, u, 12'h000},
                   cur_pc + 4, 1'b1);
        report_test("imm_forms", errs_start);
    endtask

    task automatic test_jal();
        int          errs_start;
        logic [20:0] off;
        errs_start = errors;
        for (int r = 0; r < 2; r++) begin
            off     = rand_bits(20) << 1;
            off[20] = (r == 0);  // backward jump first
            exec_instr(enc_j(off, 5'd5), cur_pc + 4, cur_pc + {{43{off[20]}}, off}, 1'b1);
            exec_instr(enc_r(1'b0, 5'd0, 5'd5, 3'b000, 5'd6), mregs[5], cur_pc + 4, 1'b1);
        end
        report_test("jal", errs_start);
    endtask

    task automatic test_csr();
        int          errs_start;
        logic [11:0] a;
        errs_start = errors;
        for (int i = 0; i < 4; i++) begin
            a = csr_tab[i*12 +: 12];
            exec_instr(enc_i(a, 5'd0, 3'b010, 5'd7, op_system), 64'd0, cur_pc + 4, 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            a = csr_tab[i*12 +: 12];
            load_reg(5'd8, rand_bits(32));
            exec_instr(enc_i(a, 5'd8, 3'b010, 5'd7, op_system), csr_ref(a), cur_pc + 4, 1'b1);
            csr_update(a, mregs[8]);
            exec_instr(enc_i(a, 5'd0, 3'b010, 5'd7, op_system), csr_ref(a), cur_pc + 4, 1'b1);
        end
        // unknown csr number
        exec_instr(enc_i(12'h7c0, 5'd8, 3'b010, 5'd7, op_system), 64'd0, cur_pc + 4, 1'b1);
        exec_instr(enc_i(12'h7c0, 5'd0, 3'b010, 5'd7, op_system), 64'd0, cur_pc + 4, 1'b1);
        report_test("csr", errs_start);
    endtask

    task automatic test_ecall();
        int          errs_start;
        logic [63:0] ecall_pc;
        errs_start = errors;
        load_reg(5'd9, rand_bits(32));
        exec_instr(enc_i(csr_mtvec, 5'd9, 3'b010, 5'd0, op_system), csr_ref(csr_mtvec),
                   cur_pc + 4, 1'b1);
        csr_update(csr_mtvec, mregs[9]);
        cur_pc   = rand_bits(62) << 2;
        ecall_pc = cur_pc;
        exec_instr(32'h0000_0073, 64'd0, m_mtvec, 1'b0);  // trap to mtvec
        m_mepc   = ecall_pc;
        m_mcause = 64'd11;
        exec_instr(enc_i(csr_mepc, 5'd0, 3'b010, 5'd10, op_system), m_mepc, cur_pc + 4, 1'b1);
        exec_instr(enc_i(csr_mcause, 5'd0, 3'b010, 5'd10, op_system), m_mcause,
                   cur_pc + 4, 1'b1);
        report_test("ecall", errs_start);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, a test did not finish", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        cur_pc      = 64'h0000_1000;
        lfsr_state  = 32'h76f3_acd2;
        m_mstatus   = '0;
        m_mtvec     = '0;
        m_mepc      = '0;
        m_mcause    = '0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        wait (!reset);
        @(negedge clk);
        test_reset_x0();
        test_reg_ops();
        test_imm_forms();
        test_jal();
        test_csr();
        test_ecall();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real period = 4.0
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;  // held for two rising edges
    end

    always #(period / 2.0) clk = ~clk;

endmodule

/* design/rv_exec_top.sv */
`timescale 1ns/100ps

module rv_exec_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          instr_valid,
    input  rv_exec_pkg::instr_u           instr,
    input  logic [rv_exec_pkg::xlen-1:0]  pc,
    output rv_exec_pkg::wb_t              wb
);
    import rv_exec_pkg::*;

    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic [xlen-1:0] alu_src1;
    logic [xlen-1:0] alu_src2;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] csr_rdata;
    logic [xlen-1:0] mtvec;
    logic            reg_we;
    logic [4:0]      reg_waddr;
    logic [xlen-1:0] reg_wdata;

    rv_decoder u_rv_decoder (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    rv_regfile u_rv_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (reg_we),
        .waddr  (reg_waddr),
        .wdata  (reg_wdata)
    );

    rv_operand_mux u_rv_operand_mux (
        .src_sel   (ctrl.src_sel),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .imm       (imm),
        .pc        (pc),
        .csr_rdata (csr_rdata),
        .alu_src1  (alu_src1),
        .alu_src2  (alu_src2)
    );

    rv_alu u_rv_alu (
        .alu_op (ctrl.alu_op),
        .a      (alu_src1),
        .b      (alu_src2),
        .result (alu_result)
    );

    rv_csr_file u_rv_csr_file (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .pc          (pc),
        .set_mask    (rdata1),  // csrrs mask comes from rs1
        .rdata       (csr_rdata),
        .mtvec       (mtvec)
    );

    rv_writeback u_rv_writeback (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .imm         (imm),
        .pc          (pc),
        .alu_result  (alu_result),
        .csr_rdata   (csr_rdata),
        .mtvec       (mtvec),
        .wb          (wb),
        .reg_we      (reg_we),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata)
    );

endmodule

/* design/rv_writeback.sv */
`timescale 1ns/100ps

module rv_writeback (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          instr_valid,
    input  rv_exec_pkg::ctrl_t            ctrl,
    input  logic [rv_exec_pkg::xlen-1:0]  imm,
    input  logic [rv_exec_pkg::xlen-1:0]  pc,
    input  logic [rv_exec_pkg::xlen-1:0]  alu_result,
    input  logic [rv_exec_pkg::xlen-1:0]  csr_rdata,
    input  logic [rv_exec_pkg::xlen-1:0]  mtvec,
    output rv_exec_pkg::wb_t              wb,
    output logic                          reg_we,
    output logic [4:0]                    reg_waddr,
    output logic [rv_exec_pkg::xlen-1:0]  reg_wdata
);
    import rv_exec_pkg::*;

    logic [xlen-1:0] wb_data;
    logic [xlen-1:0] next_pc;

    // csrrs returns the value before the set
    assign wb_data = ctrl.csr_set ? csr_rdata : alu_result;

    always_comb begin
        if (ctrl.ecall) begin
            next_pc = mtvec;
        end else if (ctrl.jump) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + 64'd4;
        end
    end

    // register file writes at the same edge that captures wb
    assign reg_we    = instr_valid && ctrl.reg_write && (ctrl.rd != 5'd0);
    assign reg_waddr = ctrl.rd;
    assign reg_wdata = wb_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= instr_valid;
        end
        wb.rd      <= ctrl.rd;
        wb.data    <= wb_data;
        wb.next_pc <= next_pc;
    end

endmodule

/* design/rv_csr_file.sv */
`timescale 1ns/100ps

module rv_csr_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          instr_valid,
    input  rv_exec_pkg::ctrl_t            ctrl,
    input  logic [rv_exec_pkg::xlen-1:0]  pc,
    input  logic [rv_exec_pkg::xlen-1:0]  set_mask,  // rs1 data for csrrs
    output logic [rv_exec_pkg::xlen-1:0]  rdata,
    output logic [rv_exec_pkg::xlen-1:0]  mtvec
);
    import rv_exec_pkg::*;

    logic [xlen-1:0] mstatus_q;
    logic [xlen-1:0] mtvec_q;
    logic [xlen-1:0] mepc_q;
    logic [xlen-1:0] mcause_q;
    logic            do_set;
    logic            do_ecall;

    assign do_set   = instr_valid && ctrl.csr_set;
    assign do_ecall = instr_valid && ctrl.ecall;

    // read port, old value goes to rd on csrrs
    always_comb begin
        case (ctrl.csr_addr)
            csr_mstatus: rdata = mstatus_q;
            csr_mtvec:   rdata = mtvec_q;
            csr_mepc:    rdata = mepc_q;
            csr_mcause:  rdata = mcause_q;
            default:     rdata = '0;  // unknown address
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (do_ecall) begin
            mepc_q   <= pc;
            mcause_q <= cause_ecall_m;
        end else if (do_set) begin
            case (ctrl.csr_addr)
                csr_mstatus: mstatus_q <= mstatus_q | set_mask;
                csr_mtvec:   mtvec_q   <= mtvec_q | set_mask;
                csr_mepc:    mepc_q    <= mepc_q | set_mask;
                csr_mcause:  mcause_q  <= mcause_q | set_mask;
                default: begin
                end
            endcase
        end
    end

    assign mtvec = mtvec_q;  // trap target for next_pc

endmodule

/* design/rv_alu.sv */
`timescale 1ns/100ps

module rv_alu (
    input  rv_exec_pkg::alu_op_e          alu_op,
    input  logic [rv_exec_pkg::xlen-1:0]  a,
    input  logic [rv_exec_pkg::xlen-1:0]  b,
    output logic [rv_exec_pkg::xlen-1:0]  result
);
    import rv_exec_pkg::*;

    logic [5:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[5:0];  // rv64 shift amount
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                result = $signed(a) >>> shamt;
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* design/rv_operand_mux.sv */
`timescale 1ns/100ps

module rv_operand_mux (
    input  rv_exec_pkg::src_sel_e         src_sel,
    input  logic [rv_exec_pkg::xlen-1:0]  rdata1,
    input  logic [rv_exec_pkg::xlen-1:0]  rdata2,
    input  logic [rv_exec_pkg::xlen-1:0]  imm,
    input  logic [rv_exec_pkg::xlen-1:0]  pc,
    input  logic [rv_exec_pkg::xlen-1:0]  csr_rdata,
    output logic [rv_exec_pkg::xlen-1:0]  alu_src1,
    output logic [rv_exec_pkg::xlen-1:0]  alu_src2
);
    import rv_exec_pkg::*;

    always_comb begin
        alu_src1 = rdata1;  // default register pair
        alu_src2 = rdata2;
        case (src_sel)
            src_reg: begin
                alu_src2 = rdata2;
            end
            src_imm: begin
                alu_src2 = imm;
            end
            src_four_pc: begin
                alu_src1 = 64'd4;  // return address for jal
                alu_src2 = pc;
            end
            src_imm_pc: begin
                alu_src1 = imm;
                alu_src2 = pc;
            end
            src_csr: begin
                alu_src2 = csr_rdata;  // already selected by csr address
            end
            src_zero_imm: begin
                alu_src1 = '0;  // lui passes imm through the adder
                alu_src2 = imm;
            end
            default: begin
            end
        endcase
    end

endmodule

/* design/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [4:0]                    raddr1,
    input  logic [4:0]                    raddr2,
    output logic [rv_exec_pkg::xlen-1:0]  rdata1,
    output logic [rv_exec_pkg::xlen-1:0]  rdata2,
    input  logic                          we,
    input  logic [4:0]                    waddr,
    input  logic [rv_exec_pkg::xlen-1:0]  wdata
);
    import rv_exec_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin  // x0 never written
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

/* design/rv_decoder.sv */
`timescale 1ns/100ps

module rv_decoder (
    input  rv_exec_pkg::instr_u            instr,
    output rv_exec_pkg::ctrl_t             ctrl,
    output logic [rv_exec_pkg::xlen-1:0]   imm
);
    import rv_exec_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;       // instr bit 30, sub and sra
    alu_op_e    arith_op;  // shared by OP and OP-IMM

    assign opcode = instr.r_fmt.opcode;
    assign funct3 = instr.r_fmt.funct3;
    assign alt    = instr.r_fmt.funct7[5];

    always_comb begin
        case (funct3)
            3'b000:  arith_op = alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alt ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    // immediate per instruction format, always sign extended
    always_comb begin
        case (opcode)
            op_imm, op_system: begin
                imm = {{52{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            op_lui, op_auipc: begin
                imm = {{32{instr.u_fmt.imm[19]}}, instr.u_fmt.imm, 12'h000};
            end
            op_jal: begin
                imm = {{43{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                       instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    always_comb begin
        ctrl.alu_op    = alu_add;
        ctrl.src_sel   = src_reg;
        ctrl.rd        = instr.r_fmt.rd;
        ctrl.rs1       = instr.r_fmt.rs1;
        ctrl.rs2       = instr.r_fmt.rs2;
        ctrl.reg_write = 1'b0;
        ctrl.csr_set   = 1'b0;
        ctrl.ecall     = 1'b0;
        ctrl.csr_addr  = instr.i_fmt.imm;  // csr number sits in the i-type imm
        ctrl.jump      = 1'b0;
        case (opcode)
            op_reg: begin
                ctrl.alu_op    = (funct3 == 3'b000 && alt) ? alu_sub : arith_op;
                ctrl.reg_write = 1'b1;
            end
            op_imm: begin
                ctrl.alu_op    = arith_op;  // no subi
                ctrl.src_sel   = src_imm;
                ctrl.reg_write = 1'b1;
            end
            op_lui: begin
                ctrl.src_sel   = src_zero_imm;
                ctrl.reg_write = 1'b1;
            end
            op_auipc: begin
                ctrl.src_sel   = src_imm_pc;
                ctrl.reg_write = 1'b1;
            end
            op_jal: begin
                ctrl.src_sel   = src_four_pc;  // link value pc + 4
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
            end
            op_system: begin
                if (funct3 == 3'b010) begin
                    ctrl.alu_op    = alu_or;
                    ctrl.src_sel   = src_csr;
                    ctrl.csr_set   = 1'b1;
                    ctrl.reg_write = 1'b1;
                end else if (funct3 == 3'b000 && instr.i_fmt.imm == 12'h000) begin
                    ctrl.ecall = 1'b1;
                end
                // ebreak, mret and other csr ops fall through as no-ops
            end
            default: begin
            end
        endcase
    end

endmodule

/* design/rv_exec_pkg.sv */
package rv_exec_pkg;

    localparam int xlen = 64;

    // major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    // machine csr addresses
    localparam logic [11:0] csr_mstatus = 12'd768;
    localparam logic [11:0] csr_mtvec   = 12'd773;
    localparam logic [11:0] csr_mepc    = 12'd833;
    localparam logic [11:0] csr_mcause  = 12'd834;

    localparam logic [xlen-1:0] cause_ecall_m = 64'd11;  // environment call from m-mode

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_e;

    typedef enum logic [2:0] {
        src_reg,       // rs1, rs2
        src_imm,       // rs1, imm
        src_four_pc,   // 4, pc
        src_imm_pc,    // imm, pc
        src_csr,       // rs1, csr
        src_zero_imm   // 0, imm
    } src_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm;  // bits 31:12 of the value
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, four views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        alu_op_e     alu_op;
        src_sel_e    src_sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        reg_write;
        logic        csr_set;   // csrrs
        logic        ecall;
        logic [11:0] csr_addr;
        logic        jump;      // jal
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
        logic [xlen-1:0] next_pc;
    } wb_t;

endpackage
